// ==== clk_step_ctl.f ====
hdl/clk_step_cfg_pkg.sv
hdl/clk_step_types_pkg.sv
hdl/step_req_sync.sv
hdl/coin_edge_timer.sv
hdl/nstep_counter.sv
hdl/clk_step_ctl.sv
test/clk_step_clkgen.sv
test/tb_clk_step.sv

// ==== hdl/clk_step_cfg_pkg.sv ====
package clk_step_cfg_pkg;

   // -------------------------------------------------------------------
   // counter widths
   // -------------------------------------------------------------------

   // step count loaded over the test access path
   localparam int STEP_W = 4;
   // alignment period, same width as the divider lcm
   localparam int LCM_W = 14;

   // -------------------------------------------------------------------
   // special values and fixed latencies
   // -------------------------------------------------------------------

   // all ones count keeps the clock enabled with no end
   localparam logic [STEP_W-1:0] STEP_ALWAYS = 4'd15;
   // alignment counter value that flags the coincident edge
   localparam logic [LCM_W-1:0] COIN_TAP = 14'd3;
   // flops in the trigger synchronizer
   localparam int SYNC_STAGES = 2;
   // coin_edge pulse to first select cycle of a burst
   localparam int START_LAT = 3;

endpackage

// ==== hdl/clk_step_ctl.sv ====
`timescale 1ns/10ps

module clk_step_ctl
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                align_rst_n,
   input  logic                                trigger,
   input  clk_step_types_pkg::step_cfg_t       cfg,
   input  logic                                cfg_valid,
   input  logic [clk_step_cfg_pkg::LCM_W-1:0]  div_mult,
   input  clk_step_types_pkg::step_mode_t      mode,
   output logic                                cfg_ready,
   output clk_step_types_pkg::step_status_t    status
);

   logic                                trig_sync;
   logic [clk_step_cfg_pkg::STEP_W-1:0] init_cnt;
   logic                                coin_edge;
   logic                                busy;
   logic                                step_sel;
   // start one-shots made visible here for debug
   clk_step_types_pkg::step_evt_t       evt;

   // -------------------------------------------------------------------
   // block instances
   // -------------------------------------------------------------------

   step_req_sync u_req_sync (
      .clk       (clk),
      .rst_n     (rst_n),
      .trigger   (trigger),
      .cfg       (cfg),
      .cfg_valid (cfg_valid),
      .cfg_ready (cfg_ready),
      .busy      (busy),
      .trig_sync (trig_sync),
      .init_cnt  (init_cnt)
   );

   coin_edge_timer u_coin_timer (
      .clk         (clk),
      .align_rst_n (align_rst_n),
      .div_mult    (div_mult),
      .coin_edge   (coin_edge)
   );

   nstep_counter u_nstep_cnt (
      .clk       (clk),
      .rst_n     (rst_n),
      .trig_sync (trig_sync),
      .coin_edge (coin_edge),
      .init_cnt  (init_cnt),
      .mode      (mode),
      .evt       (evt),
      .step_sel  (step_sel),
      .busy      (busy)
   );

   assign status.step_sel  = step_sel;
   assign status.coin_edge = coin_edge;
   assign status.busy      = busy;

   // nonzero unmasked burst opens START_LAT cycles after coin_edge
   burst_lat_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (evt.start_1sht && (init_cnt != '0) && mode.test_mode_off && !mode.force_en)
      |-> ##(clk_step_cfg_pkg::START_LAT - 1) status.step_sel
   )
   else $error("clk_step_ctl: first select cycle late or missing");

endmodule

// ==== hdl/clk_step_types_pkg.sv ====
package clk_step_types_pkg;

   // -------------------------------------------------------------------
   // configuration word from the test access path
   // -------------------------------------------------------------------

   // count plus domain match bit, loaded in one valid/ready transfer
   typedef struct packed {
      logic [clk_step_cfg_pkg::STEP_W-1:0] count;
      // clear means the transfer targets another domain
      logic                                dom_match;
   } step_cfg_t;

   // -------------------------------------------------------------------
   // static mode controls
   // -------------------------------------------------------------------

   typedef struct packed {
      // high in functional mode, low in test mode
      logic test_mode_off;
      // clock forced on elsewhere, select must stay quiet
      logic force_en;
   } step_mode_t;

   // -------------------------------------------------------------------
   // internal events and status
   // -------------------------------------------------------------------

   // start one-shot and its copy one cycle later, for debug
   typedef struct packed {
      logic start_1sht;
      logic start_1sht_dly;
   } step_evt_t;

   typedef struct packed {
      logic step_sel;
      logic coin_edge;
      logic busy;
   } step_status_t;

endpackage

// ==== hdl/coin_edge_timer.sv ====
`timescale 1ns/10ps

module coin_edge_timer
(
   input  logic                                clk,
   input  logic                                align_rst_n,
   input  logic [clk_step_cfg_pkg::LCM_W-1:0]  div_mult,
   output logic                                coin_edge
);

   // alignment down-counter, runs div_mult down to 1
   logic [clk_step_cfg_pkg::LCM_W-1:0] lcm_cnt;
   logic [clk_step_cfg_pkg::LCM_W-1:0] lcm_cnt_nxt;
   // counter at 1, or at 0 straight after restart
   logic                               reload;

   // -------------------------------------------------------------------
   // lcm counter for repeatable burst placement
   // -------------------------------------------------------------------

   assign reload = ~|lcm_cnt[clk_step_cfg_pkg::LCM_W-1:1];

   // period is div_mult cycles, one value per cycle
   assign lcm_cnt_nxt = reload ? div_mult
                               : lcm_cnt - clk_step_cfg_pkg::LCM_W'(1);

   // restart leaves 0 so the next edge loads div_mult
   always_ff @(posedge clk or negedge align_rst_n)
   begin
      if (!align_rst_n)
      begin
         lcm_cnt   <= '0;
         coin_edge <= 1'b0;
      end
      else
      begin
         lcm_cnt   <= lcm_cnt_nxt;
         // registered tap gives a glitch free aligned pulse
         coin_edge <= (lcm_cnt == clk_step_cfg_pkg::COIN_TAP);
      end
   end

   // div_mult below 4 would bring pulses closer than four cycles
   coin_single_a : assert property (
      @(posedge clk) disable iff (!align_rst_n)
      coin_edge |-> !$past(coin_edge, 1) && !$past(coin_edge, 2) && !$past(coin_edge, 3)
   )
   else $error("coin_edge_timer: coin_edge pulses less than four cycles apart");

endmodule

// ==== hdl/nstep_counter.sv ====
`timescale 1ns/10ps

module nstep_counter
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                trig_sync,
   input  logic                                coin_edge,
   input  logic [clk_step_cfg_pkg::STEP_W-1:0] init_cnt,
   input  clk_step_types_pkg::step_mode_t      mode,
   output clk_step_types_pkg::step_evt_t       evt,
   output logic                                step_sel,
   output logic                                busy
);

   logic                                start_q;
   logic                                start_nxt;
   logic                                start_dly;
   logic                                start_dly1;
   logic                                start_1sht;
   logic                                start_1sht_dly;
   logic [clk_step_cfg_pkg::STEP_W-1:0] cnt;
   logic [clk_step_cfg_pkg::STEP_W-1:0] cnt_nxt;
   logic                                en_nxt;
   logic                                sel_pre;

   // -------------------------------------------------------------------
   // start latch and one-shots
   // -------------------------------------------------------------------

   // trigger only counts at the coincident edge, held in between
   assign start_nxt = coin_edge ? trig_sync : start_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         start_q    <= 1'b0;
         start_dly  <= 1'b0;
         start_dly1 <= 1'b0;
      end
      else
      begin
         start_q    <= start_nxt;
         start_dly  <= start_q;
         start_dly1 <= start_dly;
      end
   end

   // one cycle after coin_edge, then one more
   assign start_1sht     = start_q & ~start_dly;
   assign start_1sht_dly = start_dly & ~start_dly1;

   assign evt.start_1sht     = start_1sht;
   assign evt.start_1sht_dly = start_1sht_dly;

   // -------------------------------------------------------------------
   // step down-counter and select enable
   // -------------------------------------------------------------------

   // load on start, count down once per select cycle
   assign cnt_nxt = start_1sht            ? init_cnt :
                    (sel_pre && |cnt)     ? cnt - clk_step_cfg_pkg::STEP_W'(1) :
                    cnt;

   // count of 1 never gets cnt >= 2, so it waits for the delayed one-shot
   // count of 15 keeps the enable on with or without a burst
   assign en_nxt = ((init_cnt == clk_step_cfg_pkg::STEP_W'(1)) & start_1sht_dly)
                 | (|cnt[clk_step_cfg_pkg::STEP_W-1:1])
                 | (init_cnt == clk_step_cfg_pkg::STEP_ALWAYS);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt     <= '0;
         sel_pre <= 1'b0;
      end
      else
      begin
         cnt     <= cnt_nxt;
         sel_pre <= en_nxt;
      end
   end

   // forced clock or test mode owns the gate, select stays low
   assign step_sel = sel_pre & ~mode.force_en & mode.test_mode_off;

   // burst runs until the last step has been taken
   assign busy = start_1sht | (|cnt);

   // zero count must never open the clock gate
   sel_zero_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      $rose(step_sel) |-> (init_cnt != '0)
   )
   else $error("nstep_counter: step_sel rose with init_cnt of 0");

endmodule

// ==== hdl/step_req_sync.sv ====
`timescale 1ns/10ps

module step_req_sync
(
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   trigger,
   input  clk_step_types_pkg::step_cfg_t          cfg,
   input  logic                                   cfg_valid,
   output logic                                   cfg_ready,
   input  logic                                   busy,
   output logic                                   trig_sync,
   output logic [clk_step_cfg_pkg::STEP_W-1:0]    init_cnt
);

   // shift register of the trigger synchronizer, bit 0 sees the raw level
   logic [clk_step_cfg_pkg::SYNC_STAGES-1:0] trig_ff;
   // one-cycle load event
   logic                                     cfg_fire;

   // -------------------------------------------------------------------
   // trigger synchronizer
   // -------------------------------------------------------------------

   // level comes from the tck side with no relation to clk
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         trig_ff <= '0;
      end
      else
      begin
         trig_ff <= {trig_ff[clk_step_cfg_pkg::SYNC_STAGES-2:0], trigger};
      end
   end

   // rising edge is found later, at the coincident edge sample
   assign trig_sync = trig_ff[clk_step_cfg_pkg::SYNC_STAGES-1];

   // -------------------------------------------------------------------
   // step configuration load
   // -------------------------------------------------------------------

   // no new count while a burst still reads the old one
   assign cfg_ready = ~busy;
   assign cfg_fire  = cfg_valid & cfg_ready;

   // other domain accepts the transfer but keeps the count
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         init_cnt <= '0;
      end
      else if (cfg_fire && cfg.dom_match)
      begin
         init_cnt <= cfg.count;
      end
   end

   // source must hold the word until the burst ends and ready returns
   cfg_hold_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (cfg_valid && !cfg_ready) |=> (cfg_valid && $stable(cfg))
   )
   else $error("step_req_sync: cfg dropped or changed while cfg_ready low");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the clk_step_ctl testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
   --top-module tb_clk_step \
   -f clk_step_ctl.f \
   -o sim_tb

# keep going after a crashing run so the log is still searched
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   exit 1
fi
exit 0

// ==== test/clk_step_clkgen.sv ====
`timescale 1ns/10ps

module clk_step_clkgen
(
   output logic clk,
   output logic rst_n
);

   // 8 ns period
   localparam real HALF_PERIOD = 4.0;
   // reset length in clock cycles
   localparam int RESET_CYCLES = 16;

   initial
   begin
      clk   = 1'b0;
      rst_n = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   // release on a rising edge like every other driven input
   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// ==== test/clk_step_testdata.txt ====
# name period count dom_match test_mode_off force_en expected_select_cycles
# expected 15 with count 15 means select high for the whole window
cnt5          8   5  1 1 0  5
cnt1          6   1  1 1 0  1
cnt14        12  14  1 1 0 14
cnt0          8   0  1 1 0  0
cnt2          4   2  1 1 0  2
cnt7         10   7  1 1 0  7
dom_keep7     9   3  0 1 0  7
cnt3         16   3  1 1 0  3
force_cnt9    8   9  1 1 1  0
tmode_cnt9    8   9  1 0 0  0
cnt15         8  15  1 1 0 15
force_cnt15   8  15  1 1 1  0
tmode_cnt15   6  15  1 0 0  0
cnt4_after15  8   4  1 1 0  4
dom_keep4     5   0  0 1 0  4
cnt13        20  13  1 1 0 13
cnt9          7   9  1 1 0  9
dom_keep9     4  12  0 1 0  9

// ==== test/tb_clk_step.sv ====
`timescale 1ns/10ps

module tb_clk_step;

   // watchdog budget per test in units of (div_mult + 40) cycles
   localparam int PHASE_BUDGET = 8;

   logic                                    clk;
   logic                                    rst_n;
   logic                                    align_rst_n;
   logic                                    trigger;
   clk_step_types_pkg::step_cfg_t           cfg;
   logic                                    cfg_valid;
   logic [clk_step_cfg_pkg::LCM_W-1:0]      div_mult;
   clk_step_types_pkg::step_mode_t          mode;
   logic                                    cfg_ready;
   clk_step_types_pkg::step_status_t        status;

   // test table from the data file
   string t_name[$];
   int    t_period[$];
   int    t_count[$];
   int    t_dom[$];
   int    t_tmoff[$];
   int    t_force[$];
   int    t_exp[$];

   int check_errors;
   int other_errors;
   int watchdog_cycles;
   // count in effect after the domain match rule
   int eff_count;

   clk_step_clkgen u_clkgen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   clk_step_ctl i_clk_step_ctl (
      .clk         (clk),
      .rst_n       (rst_n),
      .align_rst_n (align_rst_n),
      .trigger     (trigger),
      .cfg         (cfg),
      .cfg_valid   (cfg_valid),
      .div_mult    (div_mult),
      .mode        (mode),
      .cfg_ready   (cfg_ready),
      .status      (status)
   );

   // -------------------------------------------------------------------
   // compare tasks
   // -------------------------------------------------------------------

   task automatic check_cfg(input string name, input clk_step_types_pkg::step_cfg_t exp,
                            input clk_step_types_pkg::step_cfg_t act);
      if (exp !== act)
      begin
         check_errors++;
         $display("CHECK FAILED %s cfg: expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_status(input string name, input clk_step_types_pkg::step_status_t exp,
                               input clk_step_types_pkg::step_status_t act);
      if (exp !== act)
      begin
         check_errors++;
         $display("CHECK FAILED %s status: expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input string what, input int exp,
                              input int act);
      if (exp != act)
      begin
         check_errors++;
         $display("CHECK FAILED %s %s: expected %0d actual %0d", name, what, exp, act);
      end
   endtask

   // -------------------------------------------------------------------
   // data file
   // -------------------------------------------------------------------

   task automatic read_tests();
      int    fd;
      int    n;
      string line;
      string name;
      int    v[6];
      fd = $fopen("test/clk_step_testdata.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("cannot open test/clk_step_testdata.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         // skip blank and comment lines
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %d %d %d %d %d %d", name, v[0], v[1], v[2], v[3], v[4], v[5]);
         if (n != 7)
         begin
            other_errors++;
            $display("badly formed data line: %s", line);
            continue;
         end
         t_name.push_back(name);
         t_period.push_back(v[0]);
         t_count.push_back(v[1]);
         t_dom.push_back(v[2]);
         t_tmoff.push_back(v[3]);
         t_force.push_back(v[4]);
         t_exp.push_back(v[5]);
      end
      $fclose(fd);
   endtask

   // -------------------------------------------------------------------
   // stimulus
   // -------------------------------------------------------------------

   // one valid/ready transfer, then the effective count is compared
   task automatic load_cfg(input int idx);
      clk_step_types_pkg::step_cfg_t exp_cfg;
      clk_step_types_pkg::step_cfg_t act_cfg;
      @(negedge clk);
      while (!cfg_ready)
         @(negedge clk);
      @(posedge clk);
      cfg.count     <= clk_step_cfg_pkg::STEP_W'(t_count[idx]);
      cfg.dom_match <= 1'(t_dom[idx]);
      cfg_valid     <= 1'b1;
      @(negedge clk);
      if (!cfg_ready)
      begin
         other_errors++;
         $display("%s: cfg_ready dropped while idle", t_name[idx]);
      end
      @(posedge clk);
      cfg_valid <= 1'b0;
      // other domain keeps the old count
      if (t_dom[idx] != 0)
         eff_count = t_count[idx];
      repeat (2) @(posedge clk);
      @(negedge clk);
      exp_cfg.count     = clk_step_cfg_pkg::STEP_W'(eff_count);
      exp_cfg.dom_match = 1'b1;
      act_cfg.count     = i_clk_step_ctl.init_cnt;
      act_cfg.dom_match = 1'b1;
      check_cfg(t_name[idx], exp_cfg, act_cfg);
   endtask

   // restart alignment and look at the idle status right after
   task automatic restart_align(input int idx);
      clk_step_types_pkg::step_status_t exp_st;
      @(posedge clk);
      div_mult    <= clk_step_cfg_pkg::LCM_W'(t_period[idx]);
      align_rst_n <= 1'b0;
      @(posedge clk);
      align_rst_n <= 1'b1;
      @(negedge clk);
      // only a continuous count selects while idle
      exp_st.step_sel  = (eff_count == int'(clk_step_cfg_pkg::STEP_ALWAYS))
                         && (t_tmoff[idx] != 0) && (t_force[idx] == 0);
      exp_st.coin_edge = 1'b0;
      exp_st.busy      = 1'b0;
      check_status(t_name[idx], exp_st, status);
      check_count(t_name[idx], "cfg_ready idle", 1, int'(cfg_ready));
   endtask

   // distance between the first two coin_edge pulses
   task automatic measure_period(input int idx);
      int cyc;
      int first;
      cyc   = 0;
      first = -1;
      forever
      begin
         @(negedge clk);
         cyc++;
         if (status.coin_edge)
         begin
            if (first < 0)
               first = cyc;
            else
               break;
         end
      end
      check_count(t_name[idx], "coin_edge period", t_period[idx], cyc - first);
   endtask

   task automatic run_burst(input int idx);
      int  dm;
      int  win;
      int  total;
      int  runs;
      int  last_coin;
      bit  prev_sel;
      bit  always_on;
      dm        = t_period[idx];
      win       = 2 * dm + 24;
      total     = 0;
      runs      = 0;
      last_coin = -100;
      prev_sel  = 1'b0;
      always_on = (t_exp[idx] == int'(clk_step_cfg_pkg::STEP_ALWAYS));
      // random phase between trigger and the alignment period
      repeat (int'($urandom % 32'(dm))) @(posedge clk);
      @(posedge clk);
      trigger <= 1'b1;
      for (int c = 0; c < win; c++)
      begin
         @(negedge clk);
         if (status.step_sel)
         begin
            total++;
            if (!prev_sel)
            begin
               runs++;
               if (runs == 1 && !always_on)
                  check_count(t_name[idx], "coin_edge to select", clk_step_cfg_pkg::START_LAT,
                              c - last_coin);
            end
            if (!always_on)
            begin
               // a running burst shows up as busy on the status word
               check_count(t_name[idx], "busy during select", 1, int'(status.busy));
               if (cfg_ready)
               begin
                  other_errors++;
                  $display("%s: cfg_ready high during a select burst", t_name[idx]);
               end
            end
         end
         if (status.coin_edge)
            last_coin = c;
         prev_sel = status.step_sel;
      end
      if (always_on)
      begin
         check_count(t_name[idx], "continuous select cycles", win, total);
      end
      else
      begin
         check_count(t_name[idx], "select cycles", t_exp[idx], total);
         // one run of consecutive cycles, or none at all
         check_count(t_name[idx], "select runs", (t_exp[idx] > 0) ? 1 : 0, runs);
      end
      @(posedge clk);
      trigger <= 1'b0;
      // let the start latch see the low level at a coin_edge
      repeat (dm + 6) @(posedge clk);
   endtask

   // -------------------------------------------------------------------
   // main sequence
   // -------------------------------------------------------------------

   initial
   begin
      clk_step_types_pkg::step_status_t rst_st;
      align_rst_n      = 1'b0;
      trigger          = 1'b0;
      cfg              = '0;
      cfg_valid        = 1'b0;
      div_mult         = clk_step_cfg_pkg::LCM_W'(8);
      mode.test_mode_off = 1'b1;
      mode.force_en    = 1'b0;
      check_errors     = 0;
      other_errors     = 0;
      eff_count        = 0;
      watchdog_cycles  = 0;
      void'($urandom(82532));
      read_tests();
      if (t_name.size() == 0)
      begin
         other_errors++;
         $display("no tests found in the data file");
      end
      watchdog_cycles = 100;
      foreach (t_period[i])
         watchdog_cycles += PHASE_BUDGET * (t_period[i] + 40);

      wait (rst_n === 1'b1);
      @(negedge clk);
      // reset state
      rst_st = '0;
      check_status("after_reset", rst_st, status);
      check_count("after_reset", "cfg_ready", 1, int'(cfg_ready));

      foreach (t_name[i])
      begin
         @(posedge clk);
         mode.test_mode_off <= 1'(t_tmoff[i]);
         mode.force_en      <= 1'(t_force[i]);
         load_cfg(i);
         restart_align(i);
         measure_period(i);
         run_burst(i);
      end

      $display("errors: %0d check failures, %0d other failures", check_errors, other_errors);
      if (check_errors == 0 && other_errors == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog armed once the test table is known
   initial
   begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, test sequence hung", watchdog_cycles);
      $display("Simulation failed");
      $finish;
   end

endmodule
